// File: tb.f
+incdir+tb
hw/decode_pkg.sv
hw/imm_gen.sv
hw/alu_decode.sv
hw/mem_decode.sv
hw/branch_decode.sv
hw/uop_merge.sv
hw/decode_stage.sv
tb/tb_decode_stage.sv

// File: Makefile
SIM = obj_dir/Vtb_decode_stage
SRCS = $(shell grep -v '^+' tb.f) tb/decode_vectors.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Test passed" sim.log

$(SIM): tb.f $(SRCS)
	verilator --binary --top-module tb_decode_stage -f tb.f

clean:
	rm -rf obj_dir sim.log

// File: tb/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// row order is insn, mode64, pc offset, op, dst, dst_valid, imm kind, imm, flags
// flags are {src_a_valid, src_b_valid, is_mem, is_store, is_int, is_cheap_int, is_br}

localparam int K_NONE = 0; // rvimm not compared
localparam int K_ABS = 1; // rvimm equals the table value
localparam int K_PC = 2; // rvimm equals pc plus the table value

localparam logic [6:0] F_NONE = 7'b00_00000;
localparam logic [6:0] F_ALUI = 7'b10_00110;
localparam logic [6:0] F_ALUR = 7'b11_00110;
localparam logic [6:0] F_UI = 7'b00_00110; // lui and auipc read no register
localparam logic [6:0] F_MUL = 7'b11_00100;
localparam logic [6:0] F_LD = 7'b10_10000;
localparam logic [6:0] F_ST = 7'b11_11000;
localparam logic [6:0] F_BR = 7'b11_00111;
localparam logic [6:0] F_JAL = 7'b00_00111;
localparam logic [6:0] F_JALR = 7'b10_00111;

typedef struct {
	logic [31:0] insn;
	logic m64;
	xlen_t pc_off;
	uop_op_e op;
	reg_idx_t dst;
	logic dv;
	int kind;
	xlen_t imm;
	logic [6:0] flags;
	xlen_t pc; // filled in when driven
	int idx;
} vec_t;

vec_t vectors[$];

task automatic add_row(input logic [31:0] insn, input int m64, input xlen_t pc_off,
	input uop_op_e op, input int dst, input int dv, input int kind, input xlen_t imm,
	input logic [6:0] flags);
	vec_t r;
	r.insn = insn;
	r.m64 = (m64 != 0);
	r.pc_off = pc_off;
	r.op = op;
	r.dst = reg_idx_t'(dst);
	r.dv = (dv != 0);
	r.kind = kind;
	r.imm = imm;
	r.flags = flags;
	r.pc = '0;
	r.idx = vectors.size();
	vectors.push_back(r);
endtask

task automatic fill_vectors();
	add_row(i_type(-16, 6, 0, 5, OPC_OP_IMM), 1, 0, ADDI, 5, 1, K_ABS, -16, F_ALUI);
	add_row(i_type('h7ff, 8, 3, 7, OPC_OP_IMM), 1, 0, SLTIU, 7, 1, K_ABS, 'h7ff, F_ALUI);
	add_row(i_type(-1, 1, 4, 9, OPC_OP_IMM), 1, 0, XORI, 9, 1, K_ABS, -1, F_ALUI);
	add_row(i_type('h403, 11, 5, 10, OPC_OP_IMM), 1, 0, SRAI, 10, 1, K_ABS, 'h403, F_ALUI);
	add_row(i_type(5, 1, 7, 0, OPC_OP_IMM), 1, 0, NOP, 0, 0, K_NONE, 0, F_NONE);
	add_row(r_type('h20, 5, 4, 0, 3, OPC_OP), 1, 0, SUBU, 3, 1, K_NONE, 0, F_ALUR);
	add_row(r_type('h20, 2, 1, 5, 12, OPC_OP), 1, 0, SRA, 12, 1, K_NONE, 0, F_ALUR);
	add_row(r_type(0, 7, 6, 3, 31, OPC_OP), 1, 0, SLTU, 31, 1, K_NONE, 0, F_ALUR);
	add_row(r_type(1, 2, 3, 0, 13, OPC_OP), 1, 0, MUL, 13, 1, K_NONE, 0, F_MUL);
	add_row(r_type(1, 2, 3, 7, 14, OPC_OP), 1, 0, REMU, 14, 1, K_NONE, 0, F_MUL);
	add_row(r_type(0, 2, 3, 0, 0, OPC_OP), 1, 0, NOP, 0, 0, K_NONE, 0, F_NONE);
	add_row(i_type(-1, 6, 0, 5, OPC_OP_IMM_32), 1, 0, ADDIW, 5, 1, K_ABS, -1, F_ALUI);
	add_row(i_type(5, 6, 1, 7, OPC_OP_IMM_32), 1, 0, SLLIW, 7, 1, K_ABS, 5, F_ALUI);
	add_row(i_type('h405, 6, 5, 8, OPC_OP_IMM_32), 1, 0, SRAIW, 8, 1, K_ABS, 'h405, F_ALUI);
	add_row(r_type(0, 2, 3, 0, 4, OPC_OP_32), 1, 0, ADDW, 4, 1, K_NONE, 0, F_ALUR);
	add_row(r_type('h20, 2, 3, 0, 4, OPC_OP_32), 1, 0, SUBW, 4, 1, K_NONE, 0, F_ALUR);
	add_row(r_type(1, 2, 3, 5, 6, OPC_OP_32), 1, 0, DIVUW, 6, 1, K_NONE, 0, F_MUL);
	add_row(r_type(0, 2, 3, 0, 4, OPC_OP_32), 0, 0, II, 0, 0, K_NONE, 0, F_NONE);
	add_row(i_type(5, 6, 1, 7, OPC_OP_IMM_32), 0, 0, II, 0, 0, K_NONE, 0, F_NONE);
	add_row(i_type(-8, 2, 3, 8, OPC_LOAD), 1, 0, LD, 8, 1, K_ABS, -8, F_LD);
	add_row(i_type(100, 3, 4, 9, OPC_LOAD), 1, 0, LBU, 9, 1, K_ABS, 100, F_LD);
	add_row(i_type(0, 4, 6, 10, OPC_LOAD), 1, 0, LWU, 10, 1, K_ABS, 0, F_LD);
	add_row(i_type(4, 4, 2, 0, OPC_LOAD), 1, 0, LW, 0, 0, K_ABS, 4, F_LD);
	add_row(s_type(-4, 5, 2, 3), 1, 0, SD, 0, 0, K_ABS, -4, F_ST);
	add_row(s_type('h7ff, 6, 1, 0), 1, 0, SB, 0, 0, K_ABS, 'h7ff, F_ST);
	add_row(s_type(0, 6, 1, 4), 1, 0, II, 0, 0, K_NONE, 0, F_NONE);
	add_row(b_type(16, 2, 1, 0), 1, 0, BEQ, 0, 0, K_PC, 16, F_BR);
	add_row(b_type(-32, 2, 1, 7), 1, 0, BGEU, 0, 0, K_PC, -32, F_BR);
	add_row(b_type(8, 4, 3, 4), 0, 64'h1_0000_0000, BLT, 0, 0, K_PC, 8, F_BR);
	add_row(j_type(2048, 1), 1, 0, JAL, 1, 1, K_PC, 2048, F_JAL);
	add_row(j_type(-4, 0), 1, 0, J, 0, 0, K_PC, -4, F_JAL);
	add_row(i_type(12, 6, 0, 5, OPC_JALR), 1, 0, JALR, 5, 1, K_ABS, 12, F_JALR);
	add_row(i_type(0, 1, 0, 0, OPC_JALR), 1, 0, RET, 0, 0, K_ABS, 0, F_JALR);
	add_row(i_type(0, 5, 0, 0, OPC_JALR), 1, 0, RET, 0, 0, K_ABS, 0, F_JALR);
	add_row(i_type(8, 7, 0, 0, OPC_JALR), 1, 0, JR, 0, 0, K_ABS, 8, F_JALR);
	add_row(u_type('h12345, 4, OPC_AUIPC), 1, 0, AUIPC, 4, 1, K_PC, 'h12345000, F_UI);
	add_row(u_type('h80000, 4, OPC_AUIPC), 0, 64'h1_0000_0000, AUIPC, 4, 1, K_PC,
		64'hffff_ffff_8000_0000, F_UI);
	add_row(u_type('hfffff, 7, OPC_LUI), 1, 0, LUI, 7, 1, K_ABS,
		64'hffff_ffff_ffff_f000, F_UI);
	add_row(i_type('h0ff, 0, 0, 0, OPC_MISC_MEM), 1, 0, NOP, 0, 0, K_NONE, 0, F_NONE); // fence
	add_row(32'h0000_0073, 1, 0, II, 0, 0, K_NONE, 0, F_NONE); // ecall
	add_row(i_type('h300, 2, 1, 1, 7'h73), 1, 0, II, 0, 0, K_NONE, 0, F_NONE); // csrrw
	add_row(i_type(0, 1, 0, 2, 7'h7b), 1, 0, II, 0, 0, K_NONE, 0, F_NONE);
endtask

`endif

// File: tb/tb_decode_stage.sv
`default_nettype none

module tb_decode_stage import decode_pkg::*; ();

	localparam int RST_CYCLES = 4;

	logic clk;
	logic rst;
	logic in_valid;
	logic mode64;
	fetch_t fetch;
	logic uop_valid;
	uop_t uop;

	int cycles = 0;
	logic armed = 1'b0;
	logic prev_rst;
	logic prev_in_valid;

	decode_stage u_decode_stage (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.mode64(mode64),
		.fetch(fetch),
		.uop_valid(uop_valid),
		.uop(uop)
	);

	function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
		input int f3, input int rd, input logic [6:0] opc);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
		input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
		input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] j_type(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	`include "decode_vectors.svh"

	vec_t expected[$];

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// rv32 targets wrap to a sign-extended 32-bit value
	function automatic xlen_t pc_rel_target(input xlen_t pc, input xlen_t off, input logic m64);
		xlen_t sum;
		sum = pc + off;
		return m64 ? sum : {{32{sum[31]}}, sum[31:0]};
	endfunction

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_op(input string name, input int row, input uop_op_e exp,
		input uop_op_e act);
		if (act !== exp)
			stop_with_failure($sformatf("ERROR %s row %0d: expected %h got %h", name, row, exp, act));
	endtask

	task automatic check_reg(input string name, input int row, input reg_idx_t exp,
		input reg_idx_t act);
		if (act !== exp)
			stop_with_failure($sformatf("ERROR %s row %0d: expected %h got %h", name, row, exp, act));
	endtask

	task automatic check_xlen(input string name, input int row, input xlen_t exp,
		input xlen_t act);
		if (act !== exp)
			stop_with_failure($sformatf("ERROR %s row %0d: expected %h got %h", name, row, exp, act));
	endtask

	task automatic check_flag(input string name, input int row, input logic exp,
		input logic act);
		if (act !== exp)
			stop_with_failure($sformatf("ERROR %s row %0d: expected %h got %h", name, row, exp, act));
	endtask

	task automatic compare_uop(input vec_t e);
		check_op("uop.op", e.idx, e.op, uop.op);
		check_xlen("uop.pc", e.idx, e.pc, uop.pc);
		check_flag("uop.dst_valid", e.idx, e.dv, uop.dst_valid);
		if (e.dv)
			check_reg("uop.dst", e.idx, e.dst, uop.dst);
		check_flag("uop.src_a_valid", e.idx, e.flags[6], uop.src_a_valid);
		check_flag("uop.src_b_valid", e.idx, e.flags[5], uop.src_b_valid);
		if (e.flags[6])
			check_reg("uop.src_a", e.idx, reg_idx_t'(e.insn[19:15]), uop.src_a);
		if (e.flags[5])
			check_reg("uop.src_b", e.idx, reg_idx_t'(e.insn[24:20]), uop.src_b);
		if (e.kind != K_NONE)
			check_xlen("uop.rvimm", e.idx, e.imm, uop.rvimm);
		check_flag("uop.is_mem", e.idx, e.flags[4], uop.is_mem);
		check_flag("uop.is_store", e.idx, e.flags[3], uop.is_store);
		check_flag("uop.is_int", e.idx, e.flags[2], uop.is_int);
		check_flag("uop.is_cheap_int", e.idx, e.flags[1], uop.is_cheap_int);
		check_flag("uop.is_br", e.idx, e.flags[0], uop.is_br);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= RST_CYCLES + vectors.size() + 20)
		begin
			$display("timeout: the run did not finish after %0d cycles", cycles);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	// valid must follow in_valid by one cycle, and low right after reset
	always @(posedge clk)
	begin
		if (armed)
		begin
			check_flag("uop_valid", -1, prev_rst ? 1'b0 : prev_in_valid, uop_valid);
			if (uop_valid === 1'b1)
			begin
				if (expected.size() == 0)
					stop_with_failure("uop_valid went high with no instruction outstanding");
				compare_uop(expected.pop_front());
			end
		end
		prev_rst = rst;
		prev_in_valid = in_valid;
		armed = 1'b1;
	end

	initial
	begin
		vec_t row;
		logic [31:0] seed;
		rst = 1'b1;
		in_valid = 1'b0;
		mode64 = 1'b0;
		fetch = '0;
		seed = 32'h7395;
		fill_vectors();
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < vectors.size(); i++)
		begin
			if (i % 5 == 4)
			begin
				@(posedge clk);
				in_valid <= 1'b0; // idle gap
			end
			@(posedge clk);
			seed = lcg_next(seed);
			row = vectors[i];
			row.pc = {32'd0, seed[31:2], 2'b00} + row.pc_off;
			if (row.kind == K_PC)
				row.imm = pc_rel_target(row.pc, row.imm, row.m64);
			in_valid <= 1'b1;
			mode64 <= row.m64;
			fetch.insn <= row.insn;
			fetch.pc <= row.pc;
			expected.push_back(row);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		while (expected.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`default_nettype none

module decode_stage import decode_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic mode64,
	input fetch_t fetch,
	output logic uop_valid,
	output uop_t uop
);

	imm_set_t imm;
	uop_t alu_uop;
	uop_t mem_uop;
	uop_t br_uop;

	imm_gen u_imm_gen (
		.fetch(fetch),
		.mode64(mode64),
		.imm(imm)
	);

	alu_decode u_alu_decode (
		.insn(fetch.insn),
		.pc(fetch.pc),
		.mode64(mode64),
		.imm(imm),
		.alu_uop(alu_uop)
	);

	mem_decode u_mem_decode (
		.insn(fetch.insn),
		.pc(fetch.pc),
		.imm(imm),
		.mem_uop(mem_uop)
	);

	branch_decode u_branch_decode (
		.insn(fetch.insn),
		.pc(fetch.pc),
		.imm(imm),
		.br_uop(br_uop)
	);

	uop_merge u_uop_merge (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.insn(fetch.insn),
		.pc(fetch.pc),
		.alu_uop(alu_uop),
		.mem_uop(mem_uop),
		.br_uop(br_uop),
		.uop(uop),
		.uop_valid(uop_valid)
	);

endmodule

`default_nettype wire

// File: hw/uop_merge.sv
`default_nettype none

module uop_merge import decode_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic [31:0] insn,
	input xlen_t pc,
	input uop_t alu_uop,
	input uop_t mem_uop,
	input uop_t br_uop,
	output uop_t uop,
	output logic uop_valid
);

	opcode_e opc;
	uop_t fixed_uop;
	uop_t next_uop;

	assign opc = opcode_e'(insn[6:0]);

	always_comb
	begin
		fixed_uop = '0;
		fixed_uop.op = (opc == OPC_MISC_MEM) ? NOP : II; // fence needs no ordering here
		fixed_uop.pc = pc;
		case (opc)
			OPC_OP_IMM, OPC_OP, OPC_OP_IMM_32, OPC_OP_32, OPC_LUI, OPC_AUIPC:
				next_uop = alu_uop;
			OPC_LOAD, OPC_STORE:
				next_uop = mem_uop;
			OPC_BRANCH, OPC_JAL, OPC_JALR:
				next_uop = br_uop;
			default:
				next_uop = fixed_uop; // system and unknown opcodes
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			uop_valid <= 1'b0;
		else
			uop_valid <= in_valid;
		if (in_valid)
			uop <= next_uop;
	end

endmodule

`default_nettype wire

// File: hw/branch_decode.sv
`default_nettype none

module branch_decode import decode_pkg::*; (
	input logic [31:0] insn,
	input xlen_t pc,
	input imm_set_t imm,
	output uop_t br_uop
);

	reg_idx_t rd;
	reg_idx_t rs1;
	uop_op_e op;
	logic ok;

	assign rd = to_reg(insn[11:7]);
	assign rs1 = to_reg(insn[19:15]);

	always_comb
	begin
		case (insn[6:0])
			OPC_JAL: op = (rd == '0) ? J : JAL;
			OPC_JALR:
				if (insn[14:12] != 3'd0)
					op = II;
				else if (rd == '0)
					op = is_link(rs1) ? RET : JR; // pops the return stack
				else
					op = JALR;
			default:
				case (insn[14:12])
					3'd0: op = BEQ;
					3'd1: op = BNE;
					3'd4: op = BLT;
					3'd5: op = BGE;
					3'd6: op = BLTU;
					3'd7: op = BGEU;
					default: op = II;
				endcase
		endcase
	end

	assign ok = (op != II);

	always_comb
	begin
		br_uop = '0;
		br_uop.op = op;
		br_uop.dst = rd;
		br_uop.src_a = rs1;
		br_uop.src_b = to_reg(insn[24:20]);
		br_uop.dst_valid = (op == JAL) || (op == JALR);
		br_uop.src_a_valid = ok && (insn[6:0] != OPC_JAL);
		br_uop.src_b_valid = ok && (insn[6:0] == OPC_BRANCH);
		br_uop.rvimm = (insn[6:0] == OPC_JALR) ? imm.i_imm : imm.pc_target;
		br_uop.pc = pc;
		br_uop.is_int = ok;
		br_uop.is_cheap_int = ok;
		br_uop.is_br = ok;
	end

endmodule

`default_nettype wire

// File: hw/mem_decode.sv
`default_nettype none

module mem_decode import decode_pkg::*; (
	input logic [31:0] insn,
	input xlen_t pc,
	input imm_set_t imm,
	output uop_t mem_uop
);

	logic store;
	logic ok;
	uop_op_e op;

	assign store = insn[5]; // 0x23 vs 0x03

	always_comb
	begin
		op = II;
		if (store)
			case (insn[14:12])
				3'd0: op = SB;
				3'd1: op = SH;
				3'd2: op = SW;
				3'd3: op = SD;
				default: op = II;
			endcase
		else
			case (insn[14:12])
				3'd0: op = LB;
				3'd1: op = LH;
				3'd2: op = LW;
				3'd3: op = LD;
				3'd4: op = LBU;
				3'd5: op = LHU;
				3'd6: op = LWU;
				default: op = II;
			endcase
	end

	assign ok = (op != II);

	always_comb
	begin
		mem_uop = '0;
		mem_uop.op = op;
		mem_uop.dst = to_reg(insn[11:7]);
		mem_uop.src_a = to_reg(insn[19:15]);
		mem_uop.src_b = to_reg(insn[24:20]);
		mem_uop.dst_valid = ok && !store && (insn[11:7] != 5'd0); // load to x0 still accesses
		mem_uop.src_a_valid = ok;
		mem_uop.src_b_valid = ok && store; // store data
		mem_uop.rvimm = store ? imm.s_imm : imm.i_imm;
		mem_uop.pc = pc;
		mem_uop.is_mem = ok;
		mem_uop.is_store = ok && store;
	end

endmodule

`default_nettype wire

// File: hw/alu_decode.sv
`default_nettype none

module alu_decode import decode_pkg::*; (
	input logic [31:0] insn,
	input xlen_t pc,
	input logic mode64,
	input imm_set_t imm,
	output uop_t alu_uop
);

	logic [2:0] f3;
	logic [6:0] f7;
	logic [5:0] f6;
	reg_idx_t rd;
	uop_op_e op;
	logic use_a;
	logic use_b;
	logic cheap;
	logic live;
	xlen_t rvimm;

	assign f3 = insn[14:12];
	assign f7 = insn[31:25];
	assign f6 = insn[31:26]; // rv64 shifts use a 6-bit shamt
	assign rd = to_reg(insn[11:7]);

	always_comb
	begin
		op = II;
		use_a = 1'b1;
		use_b = 1'b0;
		cheap = 1'b1;
		rvimm = imm.i_imm;
		case (insn[6:0])
			OPC_OP_IMM:
				case (f3)
					3'd0: op = ADDI;
					3'd1: op = (f6 == 6'h00) ? SLLI : II;
					3'd2: op = SLTI;
					3'd3: op = SLTIU;
					3'd4: op = XORI;
					3'd5: op = (f6 == 6'h00) ? SRLI : (f6 == 6'h10) ? SRAI : II;
					3'd6: op = ORI;
					default: op = ANDI;
				endcase
			OPC_OP:
			begin
				use_b = 1'b1;
				cheap = (f7 != 7'h01); // mul/div go to the long pipe
				case ({f7, f3})
					{7'h00, 3'd0}: op = ADDU;
					{7'h20, 3'd0}: op = SUBU;
					{7'h00, 3'd1}: op = SLL;
					{7'h00, 3'd2}: op = SLT;
					{7'h00, 3'd3}: op = SLTU;
					{7'h00, 3'd4}: op = XOR;
					{7'h00, 3'd5}: op = SRL;
					{7'h20, 3'd5}: op = SRA;
					{7'h00, 3'd6}: op = OR;
					{7'h00, 3'd7}: op = AND;
					{7'h01, 3'd0}: op = MUL;
					{7'h01, 3'd1}: op = MULH;
					{7'h01, 3'd2}: op = MULHSU;
					{7'h01, 3'd3}: op = MULHU;
					{7'h01, 3'd4}: op = DIV;
					{7'h01, 3'd5}: op = DIVU;
					{7'h01, 3'd6}: op = REM;
					{7'h01, 3'd7}: op = REMU;
					default: op = II;
				endcase
			end
			OPC_OP_IMM_32:
				if (mode64)
					case (f3)
						3'd0: op = ADDIW;
						3'd1: op = (f7 == 7'h00) ? SLLIW : II;
						3'd5: op = (f7 == 7'h00) ? SRLIW : (f7 == 7'h20) ? SRAIW : II;
						default: op = II;
					endcase
			OPC_OP_32:
				if (mode64)
				begin
					use_b = 1'b1;
					cheap = (f7 != 7'h01);
					case ({f7, f3})
						{7'h00, 3'd0}: op = ADDW;
						{7'h20, 3'd0}: op = SUBW;
						{7'h00, 3'd1}: op = SLLW;
						{7'h00, 3'd5}: op = SRLW;
						{7'h20, 3'd5}: op = SRAW;
						{7'h01, 3'd0}: op = MULW;
						{7'h01, 3'd4}: op = DIVW;
						{7'h01, 3'd5}: op = DIVUW;
						{7'h01, 3'd6}: op = REMW;
						{7'h01, 3'd7}: op = REMUW;
						default: op = II;
					endcase
				end
			OPC_LUI:
			begin
				op = LUI;
				use_a = 1'b0;
				rvimm = imm.u_imm;
			end
			default:
			begin
				op = AUIPC;
				use_a = 1'b0;
				rvimm = imm.pc_target;
			end
		endcase
	end

	// writes to x0 have no effect
	assign live = (op != II) && (rd != '0);

	always_comb
	begin
		alu_uop = '0;
		alu_uop.op = ((op != II) && (rd == '0)) ? NOP : op;
		alu_uop.dst = rd;
		alu_uop.src_a = to_reg(insn[19:15]);
		alu_uop.src_b = to_reg(insn[24:20]);
		alu_uop.dst_valid = live;
		alu_uop.src_a_valid = live & use_a;
		alu_uop.src_b_valid = live & use_b;
		alu_uop.rvimm = rvimm;
		alu_uop.pc = pc;
		alu_uop.is_int = live;
		alu_uop.is_cheap_int = live & cheap;
	end

endmodule

`default_nettype wire

// File: hw/imm_gen.sv
`default_nettype none

module imm_gen import decode_pkg::*; (
	input fetch_t fetch,
	input logic mode64,
	output imm_set_t imm
);

	logic [31:0] insn;
	xlen_t u_imm;
	xlen_t b_imm;
	xlen_t j_imm;
	xlen_t off;
	xlen_t sum;

	assign insn = fetch.insn;
	assign u_imm = {{(XLEN-32){insn[31]}}, insn[31:12], 12'd0};
	assign b_imm = {{(XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
	assign j_imm = {{(XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

	always_comb
	begin
		case (insn[6:0])
			OPC_BRANCH: off = b_imm;
			OPC_JAL: off = j_imm;
			default: off = u_imm; // auipc
		endcase
	end

	assign sum = fetch.pc + off;

	assign imm.i_imm = sext12(insn[31:20]);
	assign imm.s_imm = sext12({insn[31:25], insn[11:7]});
	assign imm.u_imm = u_imm;
	assign imm.pc_target = mode64 ? sum : {{(XLEN-32){sum[31]}}, sum[31:0]}; // rv32 wraps

endmodule

`default_nettype wire

// File: hw/decode_pkg.sv
`default_nettype none

package decode_pkg;

	localparam int XLEN = 64;
	localparam int LG_PRF = 6;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [LG_PRF-1:0] reg_idx_t;

	typedef enum logic [6:0] {
		OPC_LOAD      = 7'h03,
		OPC_MISC_MEM  = 7'h0f,
		OPC_OP_IMM    = 7'h13,
		OPC_AUIPC     = 7'h17,
		OPC_OP_IMM_32 = 7'h1b,
		OPC_STORE     = 7'h23,
		OPC_OP        = 7'h33,
		OPC_LUI       = 7'h37,
		OPC_OP_32     = 7'h3b,
		OPC_BRANCH    = 7'h63,
		OPC_JALR      = 7'h67,
		OPC_JAL       = 7'h6f
	} opcode_e;

	typedef enum logic [7:0] {
		NOP = 8'd0, II,
		ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
		AUIPC, LUI,
		ADDIW, SLLIW, SRLIW, SRAIW,
		ADDU, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
		ADDW, SUBW, SLLW, SRLW, SRAW,
		MULW, DIVW, DIVUW, REMW, REMUW,
		LB, LH, LW, LD, LBU, LHU, LWU,
		SB, SH, SW, SD,
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		JAL, J, JALR, JR, RET
	} uop_op_e;

	typedef struct packed {
		logic [31:0] insn;
		xlen_t pc;
	} fetch_t;

	typedef struct packed {
		uop_op_e op;
		reg_idx_t dst;
		reg_idx_t src_a;
		reg_idx_t src_b;
		logic dst_valid;
		logic src_a_valid;
		logic src_b_valid;
		xlen_t rvimm;
		xlen_t pc;
		logic is_mem;
		logic is_store;
		logic is_int;
		logic is_cheap_int;
		logic is_br;
	} uop_t;

	typedef struct packed {
		xlen_t i_imm;
		xlen_t s_imm;
		xlen_t u_imm;
		xlen_t pc_target; // branch, jal or auipc target
	} imm_set_t;

	function automatic xlen_t sext12(input logic [11:0] f);
		return {{(XLEN-12){f[11]}}, f};
	endfunction

	function automatic reg_idx_t to_reg(input logic [4:0] f);
		return {{(LG_PRF-5){1'b0}}, f};
	endfunction

	// x1 and x5 are the link registers per the calling convention
	function automatic logic is_link(input reg_idx_t r);
		return (r == reg_idx_t'(1)) || (r == reg_idx_t'(5));
	endfunction

endpackage

`default_nettype wire
